// ==== hdl/mlane_pcs_pkg.sv ====
// Shared lane count, block widths, block type codes and state types for the 4-lane PCS receive path
package mlane_pcs_pkg;

    //////////////////////////////////////////////////
    // Lane and block geometry
    //////////////////////////////////////////////////
    localparam int NUM_LANES  = 4;
    localparam int BLOCK_W    = 64;
    // x^58 + x^39 + 1
    localparam int SCR_HIST_W = 58;
    localparam int SCR_TAP    = 39;

    typedef logic [$clog2(NUM_LANES)-1:0] lane_idx_t;
    typedef logic [BLOCK_W-1:0]           block_data_t;
    typedef logic [1:0]                   sync_header_t;

    localparam sync_header_t SH_DATA = 2'b01;
    localparam sync_header_t SH_CTRL = 2'b10;

    //////////////////////////////////////////////////
    // Control block type field (payload byte 0)
    //////////////////////////////////////////////////
    typedef logic [7:0] block_type_t;

    localparam block_type_t BT_START_0 = 8'h78;
    localparam block_type_t BT_START_4 = 8'h33;
    localparam block_type_t BT_TERM_0  = 8'h87;
    localparam block_type_t BT_TERM_1  = 8'h99;
    localparam block_type_t BT_TERM_2  = 8'hAA;
    localparam block_type_t BT_TERM_3  = 8'hB4;
    localparam block_type_t BT_TERM_4  = 8'hCC;
    localparam block_type_t BT_TERM_5  = 8'hD2;
    localparam block_type_t BT_TERM_6  = 8'hE1;
    localparam block_type_t BT_TERM_7  = 8'hFF;
    localparam block_type_t BT_IDLE    = 8'h1E;

    typedef enum logic [2:0] {
        KIND_DATA,
        KIND_START,
        KIND_TERM,
        KIND_IDLE,
        KIND_INVALID
    } block_kind_t;

    // Saturates at 255
    typedef logic [7:0] err_count_t;

    //////////////////////////////////////////////////
    // Block lock
    //////////////////////////////////////////////////
    typedef logic [6:0] hdr_cnt_t;

    localparam hdr_cnt_t LOCK_GOOD_CNT = 7'd64;
    localparam hdr_cnt_t LOCK_WINDOW   = 7'd64;
    localparam hdr_cnt_t LOCK_BAD_MAX  = 7'd16;

    typedef enum logic [1:0] {
        LOCK_INIT,
        LOCK_TEST,
        LOCK_OK
    } lock_state_t;

endpackage

// ==== hdl/lane_descrambler.sv ====
// Parallel 64-bit self-synchronous descrambler for one lane, history supplied by the caller
`timescale 1ns/10ps

module lane_descrambler (
    input  mlane_pcs_pkg::block_data_t scr_data_i,
    input  mlane_pcs_pkg::block_data_t hist_i,
    output mlane_pcs_pkg::block_data_t data_o
);
    import mlane_pcs_pkg::*;

    // Previous scrambled bits below, current block above
    logic [2*BLOCK_W-1:0] stream;

    assign stream = {scr_data_i, hist_i};

    // Bit 0 is the first bit on the wire
    always_comb begin
        for (int i = 0; i < BLOCK_W; i++) begin
            data_o[i] = stream[BLOCK_W+i]
                      ^ stream[BLOCK_W+i-SCR_TAP]
                      ^ stream[BLOCK_W+i-SCR_HIST_W];
        end
    end

endmodule

// ==== hdl/descrambler_chain.sv ====
// Cross-lane descrambler stage, lane i seeded by lane i-1 and lane 0 by last cycle's lane 3
`timescale 1ns/10ps

module descrambler_chain (
    input  logic                        clk_156,
    input  logic                        async_reset_n,
    input  logic                        valid_i,
    input  mlane_pcs_pkg::sync_header_t header_i [mlane_pcs_pkg::NUM_LANES],
    input  mlane_pcs_pkg::block_data_t  data_i   [mlane_pcs_pkg::NUM_LANES],
    output logic                        valid_o,
    output mlane_pcs_pkg::sync_header_t header_o [mlane_pcs_pkg::NUM_LANES],
    output mlane_pcs_pkg::block_data_t  data_o   [mlane_pcs_pkg::NUM_LANES]
);
    import mlane_pcs_pkg::*;

    localparam lane_idx_t LAST_LANE = lane_idx_t'(NUM_LANES - 1);

    block_data_t hist_q;
    block_data_t lane_hist [NUM_LANES];
    block_data_t desc_data [NUM_LANES];

    //////////////////////////////////////////////////
    // History wiring
    //////////////////////////////////////////////////
    assign lane_hist[0] = hist_q;

    for (genvar i = 1; i < NUM_LANES; i++) begin : g_hist
        assign lane_hist[i] = data_i[i-1];
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_descrambler u_lane_descrambler (
            .scr_data_i (data_i[i]),
            .hist_i     (lane_hist[i]),
            .data_o     (desc_data[i])
        );
    end

    // Lane 3 scrambled block, kept for lane 0 of the next valid cycle
    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            hist_q  <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                hist_q <= data_i[LAST_LANE];
            end
        end
    end

    // Headers pass unscrambled
    always_ff @(posedge clk_156) begin
        if (valid_i) begin
            header_o <= header_i;
            data_o   <= desc_data;
        end
    end

    a_valid_known: assert property (
        @(posedge clk_156) disable iff (!async_reset_n) !$isunknown(valid_o)
    );

endmodule

// ==== hdl/block_classifier.sv ====
// Decodes one lane's sync header and block type field into a block kind
`timescale 1ns/10ps

module block_classifier (
    input  mlane_pcs_pkg::sync_header_t header_i,
    input  mlane_pcs_pkg::block_data_t  data_i,
    output mlane_pcs_pkg::block_kind_t  kind_o
);
    import mlane_pcs_pkg::*;

    block_type_t blk_type;

    assign blk_type = data_i[7:0];

    always_comb begin
        kind_o = KIND_INVALID;
        case (header_i)
            SH_DATA: begin
                kind_o = KIND_DATA;
            end
            SH_CTRL: begin
                case (blk_type)
                    BT_START_0,
                    BT_START_4: begin
                        kind_o = KIND_START;
                    end
                    BT_TERM_0, BT_TERM_1, BT_TERM_2, BT_TERM_3,
                    BT_TERM_4, BT_TERM_5, BT_TERM_6, BT_TERM_7: begin
                        kind_o = KIND_TERM;
                    end
                    BT_IDLE: begin
                        kind_o = KIND_IDLE;
                    end
                    default: begin
                        kind_o = KIND_INVALID;
                    end
                endcase
            end
            // 00 and 11 headers
            default: begin
                kind_o = KIND_INVALID;
            end
        endcase
    end

endmodule

// ==== hdl/frame_checker.sv ====
// Tracks packet state across lanes and cycles, flags sop, eop and errored blocks, counts errors
`timescale 1ns/10ps

module frame_checker (
    input  logic                                   clk_156,
    input  logic                                   async_reset_n,
    input  logic                                   valid_i,
    input  mlane_pcs_pkg::block_kind_t             kind_i [mlane_pcs_pkg::NUM_LANES],
    input  logic                                   clear_errblk_i,
    output logic                                   valid_o,
    output logic [mlane_pcs_pkg::NUM_LANES-1:0]    sop_o,
    output logic [mlane_pcs_pkg::NUM_LANES-1:0]    eop_o,
    output logic [mlane_pcs_pkg::NUM_LANES-1:0]    blk_err_o,
    output mlane_pcs_pkg::err_count_t              errd_blks_o
);
    import mlane_pcs_pkg::*;

    logic                 pkt_q;
    logic                 pkt_c;
    logic [NUM_LANES-1:0] sop_c;
    logic [NUM_LANES-1:0] eop_c;
    logic [NUM_LANES-1:0] err_c;
    logic [2:0]           nerr;
    logic [8:0]           cnt_sum;
    err_count_t           cnt_next;

    //////////////////////////////////////////////////
    // Lane walk, lane 0 first
    //////////////////////////////////////////////////
    always_comb begin
        pkt_c = pkt_q;
        sop_c = '0;
        eop_c = '0;
        err_c = '0;
        nerr  = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            case (kind_i[i])
                KIND_START: begin
                    err_c[i] = pkt_c;
                    sop_c[i] = !pkt_c;
                    pkt_c    = 1'b1;
                end
                KIND_TERM: begin
                    err_c[i] = !pkt_c;
                    eop_c[i] = pkt_c;
                    pkt_c    = 1'b0;
                end
                KIND_DATA: begin
                    err_c[i] = !pkt_c;
                end
                KIND_IDLE: begin
                    err_c[i] = 1'b0;
                end
                default: begin
                    err_c[i] = 1'b1;
                end
            endcase
            // Errored block ends any open packet
            if (err_c[i]) begin
                pkt_c = 1'b0;
            end
            nerr = nerr + 3'(err_c[i]);
        end
    end

    // Saturating add
    assign cnt_sum  = {1'b0, errd_blks_o} + 9'(nerr);
    assign cnt_next = cnt_sum[8] ? 8'hFF : cnt_sum[7:0];

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            pkt_q       <= 1'b0;
            valid_o     <= 1'b0;
            sop_o       <= '0;
            eop_o       <= '0;
            blk_err_o   <= '0;
            errd_blks_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                pkt_q     <= pkt_c;
                sop_o     <= sop_c;
                eop_o     <= eop_c;
                blk_err_o <= err_c;
            end else begin
                sop_o     <= '0;
                eop_o     <= '0;
                blk_err_o <= '0;
            end
            if (clear_errblk_i) begin
                errd_blks_o <= '0;
            end else if (valid_i) begin
                errd_blks_o <= cnt_next;
            end
        end
    end

    a_sop_not_err: assert property (
        @(posedge clk_156) disable iff (!async_reset_n) (sop_o & blk_err_o) == '0
    );

endmodule

// ==== hdl/block_lock_fsm.sv ====
// Block lock state machine over the sync headers of all four lanes
`timescale 1ns/10ps

module block_lock_fsm (
    input  logic                        clk_156,
    input  logic                        async_reset_n,
    input  logic                        valid_i,
    input  mlane_pcs_pkg::sync_header_t header_i [mlane_pcs_pkg::NUM_LANES],
    output logic                        block_lock_o
);
    import mlane_pcs_pkg::*;

    localparam hdr_cnt_t LANE_HDRS = hdr_cnt_t'(NUM_LANES);

    lock_state_t state_q;
    lock_state_t state_d;
    hdr_cnt_t    good_q;
    hdr_cnt_t    good_d;
    hdr_cnt_t    win_q;
    hdr_cnt_t    win_d;
    hdr_cnt_t    bad_q;
    hdr_cnt_t    bad_d;
    hdr_cnt_t    bad_sum;
    logic [2:0]  nbad;
    logic        lock_q;

    always_comb begin
        nbad = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (header_i[i] != SH_DATA && header_i[i] != SH_CTRL) begin
                nbad = nbad + 3'd1;
            end
        end
        bad_sum = bad_q + hdr_cnt_t'(nbad);
        state_d = state_q;
        good_d  = good_q;
        win_d   = win_q;
        bad_d   = bad_q;
        case (state_q)
            LOCK_INIT, LOCK_TEST: begin
                if (nbad != '0) begin
                    state_d = LOCK_INIT;
                    good_d  = '0;
                end else if (good_q + LANE_HDRS >= LOCK_GOOD_CNT) begin
                    state_d = LOCK_OK;
                    good_d  = '0;
                    win_d   = '0;
                    bad_d   = '0;
                end else begin
                    state_d = LOCK_TEST;
                    good_d  = good_q + LANE_HDRS;
                end
            end
            LOCK_OK: begin
                if (bad_sum >= LOCK_BAD_MAX) begin
                    state_d = LOCK_INIT;
                    win_d   = '0;
                    bad_d   = '0;
                end else if (win_q + LANE_HDRS >= LOCK_WINDOW) begin
                    // Window closed, start a fresh one
                    win_d = '0;
                    bad_d = '0;
                end else begin
                    win_d = win_q + LANE_HDRS;
                    bad_d = bad_sum;
                end
            end
            default: begin
                state_d = LOCK_INIT;
            end
        endcase
    end

    always_ff @(posedge clk_156 or negedge async_reset_n) begin
        if (!async_reset_n) begin
            state_q <= LOCK_INIT;
            good_q  <= '0;
            win_q   <= '0;
            bad_q   <= '0;
            lock_q  <= 1'b0;
        end else if (valid_i) begin
            state_q <= state_d;
            good_q  <= good_d;
            win_q   <= win_d;
            bad_q   <= bad_d;
            lock_q  <= (state_d == LOCK_OK);
        end
    end

    assign block_lock_o = lock_q;

    a_lock_in_ok: assert property (
        @(posedge clk_156) disable iff (!async_reset_n) block_lock_o |-> state_q == LOCK_OK
    );

endmodule

// ==== hdl/mlane_pcs_rx_top.sv ====
// Top of the 4-lane 64b/66b PCS receive path: descramble, classify, frame check and block lock
`timescale 1ns/10ps

module mlane_pcs_rx_top (
    input  logic                                clk_156,
    input  logic                                async_reset_n,
    input  logic                                rx_valid_i,
    input  mlane_pcs_pkg::sync_header_t         rx_header_i [mlane_pcs_pkg::NUM_LANES],
    input  mlane_pcs_pkg::block_data_t          rx_data_i   [mlane_pcs_pkg::NUM_LANES],
    input  logic                                clear_errblk_i,
    output logic                                rx_valid_o,
    output mlane_pcs_pkg::sync_header_t         rx_header_o [mlane_pcs_pkg::NUM_LANES],
    output mlane_pcs_pkg::block_data_t          rx_data_o   [mlane_pcs_pkg::NUM_LANES],
    output logic [mlane_pcs_pkg::NUM_LANES-1:0] sop_o,
    output logic [mlane_pcs_pkg::NUM_LANES-1:0] eop_o,
    output logic [mlane_pcs_pkg::NUM_LANES-1:0] blk_err_o,
    output mlane_pcs_pkg::err_count_t           errd_blks_o,
    output logic                                block_lock_o
);
    import mlane_pcs_pkg::*;

    logic         desc_valid;
    sync_header_t desc_header [NUM_LANES];
    block_data_t  desc_data   [NUM_LANES];
    block_kind_t  kind        [NUM_LANES];

    //////////////////////////////////////////////////
    // Stage 1 descramble
    //////////////////////////////////////////////////
    descrambler_chain u_descrambler_chain (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .valid_i       (rx_valid_i),
        .header_i      (rx_header_i),
        .data_i        (rx_data_i),
        .valid_o       (desc_valid),
        .header_o      (desc_header),
        .data_o        (desc_data)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_classify
        block_classifier u_block_classifier (
            .header_i (desc_header[i]),
            .data_i   (desc_data[i]),
            .kind_o   (kind[i])
        );
    end

    //////////////////////////////////////////////////
    // Stage 2 framing and lock
    //////////////////////////////////////////////////
    frame_checker u_frame_checker (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .valid_i        (desc_valid),
        .kind_i         (kind),
        .clear_errblk_i (clear_errblk_i),
        .valid_o        (rx_valid_o),
        .sop_o          (sop_o),
        .eop_o          (eop_o),
        .blk_err_o      (blk_err_o),
        .errd_blks_o    (errd_blks_o)
    );

    block_lock_fsm u_block_lock_fsm (
        .clk_156       (clk_156),
        .async_reset_n (async_reset_n),
        .valid_i       (desc_valid),
        .header_i      (desc_header),
        .block_lock_o  (block_lock_o)
    );

    // Keeps data and header in step with the frame flags
    always_ff @(posedge clk_156) begin
        if (desc_valid) begin
            rx_header_o <= desc_header;
            rx_data_o   <= desc_data;
        end
    end

endmodule

// ==== sim/tb_pcs_model.svh ====
// Testbench model functions (LFSR, serial scrambler, block builders), included in the testbench module
`ifndef TB_PCS_MODEL_SVH
`define TB_PCS_MODEL_SVH

// Fibonacci LFSR x^32+x^22+x^2+x+1, one step per bit taken
function automatic logic [63:0] lfsr_take(input int nbits, inout logic [31:0] state);
    logic [63:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
        state = {state[30:0], fb};
        bits  = {bits[62:0], fb};
    end
    return bits;
endfunction

// Serial x^58+x^39+1 scrambler, bit 0 leaves first and state[0] is the newest output bit
function automatic block_data_t scramble_serial(input block_data_t din, inout logic [57:0] state);
    block_data_t dout;
    logic        s;
    for (int i = 0; i < 64; i++) begin
        s       = din[i] ^ state[38] ^ state[57];
        state   = {state[56:0], s};
        dout[i] = s;
    end
    return dout;
endfunction

// Control payload with the type in byte 0
function automatic block_data_t ctrl_block(input block_type_t bt, input block_data_t fill);
    return {fill[63:8], bt};
endfunction

function automatic block_type_t term_type(input logic [2:0] idx);
    case (idx)
        3'd0:    return BT_TERM_0;
        3'd1:    return BT_TERM_1;
        3'd2:    return BT_TERM_2;
        3'd3:    return BT_TERM_3;
        3'd4:    return BT_TERM_4;
        3'd5:    return BT_TERM_5;
        3'd6:    return BT_TERM_6;
        default: return BT_TERM_7;
    endcase
endfunction

`endif

// ==== sim/tb_mlane_pcs_rx.sv ====
// Testbench that checks the 4-lane PCS receive path against a scrambler model by assertions
`timescale 1ns/10ps

module tb_mlane_pcs_rx;
    import mlane_pcs_pkg::*;

    `include "tb_pcs_model.svh"

    // Upper bound on the stimulus length in clock cycles
    localparam int TEST_CYCLES = 240;

    typedef enum logic [2:0] {
        B_DATA,
        B_START,
        B_TERM,
        B_IDLE,
        B_BADHDR,
        B_BADTYPE
    } stim_t;

    logic                 clk_156;
    logic                 async_reset_n;
    logic                 rx_valid_i;
    sync_header_t         rx_header_i [NUM_LANES];
    block_data_t          rx_data_i   [NUM_LANES];
    logic                 clear_errblk_i;
    logic                 rx_valid_o;
    sync_header_t         rx_header_o [NUM_LANES];
    block_data_t          rx_data_o   [NUM_LANES];
    logic [NUM_LANES-1:0] sop_o;
    logic [NUM_LANES-1:0] eop_o;
    logic [NUM_LANES-1:0] blk_err_o;
    err_count_t           errd_blks_o;
    logic                 block_lock_o;

    // Model state
    logic [31:0] lfsr_q;
    logic [57:0] scr_q;
    logic        m_pkt;
    logic        m_locked;
    int          m_good;
    int          m_win;
    int          m_bad;
    int          m_cnt;

    // Expected results per stage with stage 0 written by the stimulus
    logic                 exp_valid [3];
    sync_header_t         exp_hdr   [3][NUM_LANES];
    block_data_t          exp_data  [3][NUM_LANES];
    logic [NUM_LANES-1:0] exp_sop   [3];
    logic [NUM_LANES-1:0] exp_eop   [3];
    logic [NUM_LANES-1:0] exp_err   [3];
    err_count_t           exp_cnt   [3];
    logic                 exp_lock  [3];

    mlane_pcs_rx_top u_dut (
        .clk_156        (clk_156),
        .async_reset_n  (async_reset_n),
        .rx_valid_i     (rx_valid_i),
        .rx_header_i    (rx_header_i),
        .rx_data_i      (rx_data_i),
        .clear_errblk_i (clear_errblk_i),
        .rx_valid_o     (rx_valid_o),
        .rx_header_o    (rx_header_o),
        .rx_data_o      (rx_data_o),
        .sop_o          (sop_o),
        .eop_o          (eop_o),
        .blk_err_o      (blk_err_o),
        .errd_blks_o    (errd_blks_o),
        .block_lock_o   (block_lock_o)
    );

    initial begin
        clk_156 = 1'b0;
        forever #5 clk_156 = ~clk_156;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    initial begin : watchdog
        #((TEST_CYCLES + 100) * 10);
        report_failure("Timeout, the test did not reach its end in time");
    end

    // Two-cycle pipeline of expectations
    always @(posedge clk_156) begin
        for (int s = 2; s > 0; s--) begin
            exp_valid[s] <= exp_valid[s-1];
            exp_sop[s]   <= exp_sop[s-1];
            exp_eop[s]   <= exp_eop[s-1];
            exp_err[s]   <= exp_err[s-1];
            exp_cnt[s]   <= exp_cnt[s-1];
            exp_lock[s]  <= exp_lock[s-1];
            for (int l = 0; l < NUM_LANES; l++) begin
                exp_hdr[s][l]  <= exp_hdr[s-1][l];
                exp_data[s][l] <= exp_data[s-1][l];
            end
        end
    end

    //////////////////////////////////////////////////
    // Output checks
    //////////////////////////////////////////////////
    a_valid: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        rx_valid_o == exp_valid[2])
        else report_failure($sformatf("Fail rx_valid_o exp %h got %h",
            $sampled(exp_valid[2]), $sampled(rx_valid_o)));

    a_sop: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        sop_o == exp_sop[2])
        else report_failure($sformatf("Fail sop_o exp %h got %h",
            $sampled(exp_sop[2]), $sampled(sop_o)));

    a_eop: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        eop_o == exp_eop[2])
        else report_failure($sformatf("Fail eop_o exp %h got %h",
            $sampled(exp_eop[2]), $sampled(eop_o)));

    a_err: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        blk_err_o == exp_err[2])
        else report_failure($sformatf("Fail blk_err_o exp %h got %h",
            $sampled(exp_err[2]), $sampled(blk_err_o)));

    a_count: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        errd_blks_o == exp_cnt[2])
        else report_failure($sformatf("Fail errd_blks_o exp %h got %h",
            $sampled(exp_cnt[2]), $sampled(errd_blks_o)));

    a_lock: assert property (@(posedge clk_156) disable iff (!async_reset_n)
        block_lock_o == exp_lock[2])
        else report_failure($sformatf("Fail block_lock_o exp %h got %h",
            $sampled(exp_lock[2]), $sampled(block_lock_o)));

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane_chk
        a_data: assert property (@(posedge clk_156) disable iff (!async_reset_n)
            exp_valid[2] |-> rx_data_o[l] == exp_data[2][l])
            else report_failure($sformatf("Fail rx_data_o[%0d] exp %h got %h", l,
                $sampled(exp_data[2][l]), $sampled(rx_data_o[l])));

        a_hdr: assert property (@(posedge clk_156) disable iff (!async_reset_n)
            exp_valid[2] |-> rx_header_o[l] == exp_hdr[2][l])
            else report_failure($sformatf("Fail rx_header_o[%0d] exp %h got %h", l,
                $sampled(exp_hdr[2][l]), $sampled(rx_header_o[l])));
    end

    //////////////////////////////////////////////////
    // Reference model and stimulus
    //////////////////////////////////////////////////
    task automatic update_lock(input int nbad);
        if (!m_locked) begin
            if (nbad != 0) begin
                m_good = 0;
            end else begin
                m_good = m_good + NUM_LANES;
                if (m_good >= 64) begin
                    m_locked = 1'b1;
                    m_good   = 0;
                    m_win    = 0;
                    m_bad    = 0;
                end
            end
        end else begin
            m_bad = m_bad + nbad;
            m_win = m_win + NUM_LANES;
            if (m_bad >= 16) begin
                m_locked = 1'b0;
                m_win    = 0;
                m_bad    = 0;
            end else if (m_win >= 64) begin
                m_win = 0;
                m_bad = 0;
            end
        end
    endtask

    task automatic send_blocks(input stim_t s0, input stim_t s1, input stim_t s2, input stim_t s3);
        stim_t        lane_stim [NUM_LANES];
        block_data_t  payload;
        block_data_t  fill;
        logic [63:0]  sel;
        sync_header_t hdr;
        logic         err;
        int           nbad;
        int           nerr;
        lane_stim[0] = s0;
        lane_stim[1] = s1;
        lane_stim[2] = s2;
        lane_stim[3] = s3;
        nbad = 0;
        nerr = 0;
        @(negedge clk_156);
        rx_valid_i = 1'b1;
        exp_sop[0] = '0;
        exp_eop[0] = '0;
        exp_err[0] = '0;
        // Lane order 0 to 3 keeps one scrambler stream
        for (int l = 0; l < NUM_LANES; l++) begin
            fill = lfsr_take(64, lfsr_q);
            sel  = lfsr_take(3, lfsr_q);
            hdr  = SH_CTRL;
            err  = 1'b0;
            case (lane_stim[l])
                B_DATA: begin
                    hdr     = SH_DATA;
                    payload = fill;
                    err     = !m_pkt;
                end
                B_START: begin
                    payload = ctrl_block(sel[0] ? BT_START_4 : BT_START_0, fill);
                    if (m_pkt) begin
                        err = 1'b1;
                    end else begin
                        exp_sop[0][l] = 1'b1;
                    end
                    m_pkt = 1'b1;
                end
                B_TERM: begin
                    payload = ctrl_block(term_type(sel[2:0]), fill);
                    if (m_pkt) begin
                        exp_eop[0][l] = 1'b1;
                    end else begin
                        err = 1'b1;
                    end
                    m_pkt = 1'b0;
                end
                B_IDLE: begin
                    payload = ctrl_block(BT_IDLE, fill);
                end
                B_BADHDR: begin
                    hdr     = sel[0] ? 2'b11 : 2'b00;
                    payload = fill;
                    err     = 1'b1;
                    nbad    = nbad + 1;
                end
                default: begin
                    payload = ctrl_block(8'h55, fill);
                    err     = 1'b1;
                end
            endcase
            if (err) begin
                m_pkt         = 1'b0;
                exp_err[0][l] = 1'b1;
                nerr          = nerr + 1;
            end
            rx_header_i[l] = hdr;
            rx_data_i[l]   = scramble_serial(payload, scr_q);
            exp_hdr[0][l]  = hdr;
            exp_data[0][l] = payload;
        end
        m_cnt = (m_cnt + nerr > 255) ? 255 : m_cnt + nerr;
        update_lock(nbad);
        exp_valid[0] = 1'b1;
        exp_cnt[0]   = err_count_t'(m_cnt);
        exp_lock[0]  = m_locked;
    endtask

    // Garbage on the lanes with valid low must change nothing
    task automatic skip_cycle();
        @(negedge clk_156);
        rx_valid_i = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            rx_data_i[l]   = lfsr_take(64, lfsr_q);
            rx_header_i[l] = 2'b00;
        end
        exp_valid[0] = 1'b0;
        exp_sop[0]   = '0;
        exp_eop[0]   = '0;
        exp_err[0]   = '0;
        exp_cnt[0]   = err_count_t'(m_cnt);
        exp_lock[0]  = m_locked;
    endtask

    // Clear lands one edge ahead of the expectation slot it is driven in
    task automatic clear_errors();
        skip_cycle();
        m_cnt      = 0;
        exp_cnt[0] = '0;
        skip_cycle();
        clear_errblk_i = 1'b1;
        skip_cycle();
        clear_errblk_i = 1'b0;
    endtask

    function automatic stim_t stim_from_bits(input logic [2:0] bits);
        case (bits)
            3'd2:    return B_START;
            3'd3:    return B_TERM;
            3'd4,
            3'd7:    return B_IDLE;
            3'd6:    return B_BADTYPE;
            default: return B_DATA;
        endcase
    endfunction

    task automatic random_traffic(input int cycles);
        logic [63:0] r;
        for (int c = 0; c < cycles; c++) begin
            r = lfsr_take(14, lfsr_q);
            if (r[13:12] == 2'b00) begin
                skip_cycle();
            end
            send_blocks(stim_from_bits(r[2:0]), stim_from_bits(r[5:3]),
                        stim_from_bits(r[8:6]), stim_from_bits(r[11:9]));
        end
    endtask

    initial begin : stimulus
        async_reset_n  = 1'b0;
        rx_valid_i     = 1'b0;
        clear_errblk_i = 1'b0;
        lfsr_q         = 32'h25e8;
        scr_q          = '0;
        m_pkt          = 1'b0;
        m_locked       = 1'b0;
        m_good         = 0;
        m_win          = 0;
        m_bad          = 0;
        m_cnt          = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            rx_header_i[l] = '0;
            rx_data_i[l]   = '0;
        end
        for (int s = 0; s < 3; s++) begin
            exp_valid[s] = 1'b0;
            exp_sop[s]   = '0;
            exp_eop[s]   = '0;
            exp_err[s]   = '0;
            exp_cnt[s]   = '0;
            exp_lock[s]  = 1'b0;
            for (int l = 0; l < NUM_LANES; l++) begin
                exp_hdr[s][l]  = '0;
                exp_data[s][l] = '0;
            end
        end
        repeat (8) @(posedge clk_156);
        @(negedge clk_156);
        async_reset_n = 1'b1;
        repeat (2) skip_cycle();

        // Good headers up to lock
        repeat (16) send_blocks(B_IDLE, B_IDLE, B_IDLE, B_IDLE);

        // Packets over lane and cycle boundaries
        send_blocks(B_START, B_DATA, B_DATA, B_DATA);
        send_blocks(B_DATA, B_DATA, B_TERM, B_IDLE);
        send_blocks(B_IDLE, B_START, B_DATA, B_TERM);
        send_blocks(B_IDLE, B_IDLE, B_START, B_DATA);
        send_blocks(B_DATA, B_DATA, B_DATA, B_DATA);
        send_blocks(B_TERM, B_IDLE, B_IDLE, B_IDLE);
        send_blocks(B_START, B_TERM, B_START, B_TERM);
        // Open packet and lane 3 history across a gap
        send_blocks(B_IDLE, B_IDLE, B_IDLE, B_START);
        skip_cycle();
        skip_cycle();
        send_blocks(B_DATA, B_DATA, B_TERM, B_IDLE);

        // Errored blocks
        send_blocks(B_IDLE, B_BADHDR, B_BADTYPE, B_IDLE);
        send_blocks(B_START, B_DATA, B_START, B_DATA);
        send_blocks(B_DATA, B_TERM, B_IDLE, B_IDLE);
        clear_errors();

        random_traffic(40);

        // Close any packet left open so the data blocks below are all errored
        send_blocks(B_TERM, B_IDLE, B_IDLE, B_IDLE);

        // Counter saturation and clear
        repeat (70) send_blocks(B_DATA, B_DATA, B_DATA, B_DATA);
        clear_errors();

        // Loss of lock and relock
        repeat (8) send_blocks(B_BADHDR, B_BADHDR, B_BADHDR, B_BADHDR);
        repeat (16) send_blocks(B_IDLE, B_IDLE, B_IDLE, B_IDLE);

        // Drain the pipeline
        repeat (4) skip_cycle();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+sim
hdl/mlane_pcs_pkg.sv
hdl/lane_descrambler.sv
hdl/descrambler_chain.sv
hdl/block_classifier.sv
hdl/frame_checker.sv
hdl/block_lock_fsm.sv
hdl/mlane_pcs_rx_top.sv
sim/tb_mlane_pcs_rx.sv

// ==== Bender.yml ====
package:
  name: mlane_pcs_rx

sources:
  - files:
      - hdl/mlane_pcs_pkg.sv
      - hdl/lane_descrambler.sv
      - hdl/descrambler_chain.sv
      - hdl/block_classifier.sv
      - hdl/frame_checker.sv
      - hdl/block_lock_fsm.sv
      - hdl/mlane_pcs_rx_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mlane_pcs_rx.sv
